// ==== sources.f ====
+incdir+src
src/mcalu_pkg.sv
src/mcalu_decode.sv
src/mcalu_mul_pipe.sv
src/mcalu_unary_pipe.sv
src/mcalu_delay.sv
src/mcalu_select.sv
src/mcalu_top.sv
verif/mcalu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the mcalu testbench with Verilator, runs it and checks the log for the pass message

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal -f sources.f --top-module mcalu_tb -o mcalu_sim \
	> "$LOG" 2>&1 && ./obj_dir/mcalu_sim >> "$LOG" 2>&1

cat "$LOG"

grep -q "Everything OK" "$LOG" && echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }

// ==== verif/mcalu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mcalu_config.svh"

module mcalu_tb;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_ISSUES = 600;
	// Edges from the edge that drives an issue to the edge that registers its result
	localparam int LATENCY = 6;
	localparam int DRAIN_CYCLES = LATENCY + 8;
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_ISSUES + DRAIN_CYCLES + 100) * PERIOD;

	localparam mcalu_pkg::opcode_e LEGAL_OPS [6] = '{
		mcalu_pkg::OP_UNARY, mcalu_pkg::OP_MULI, mcalu_pkg::OP_MADD,
		mcalu_pkg::OP_MSUB, mcalu_pkg::OP_NMADD, mcalu_pkg::OP_NMSUB
	};
	localparam mcalu_pkg::unary_fn_e LEGAL_FNS [4] = '{
		mcalu_pkg::FN_CLZ, mcalu_pkg::FN_POPCNT, mcalu_pkg::FN_BREV, mcalu_pkg::FN_ABS
	};

	// One scoreboard entry, the edge count at which the result must show up
	typedef struct packed {
		logic [31:0]              due;
		logic [`MCALU_TAG_W-1:0]  tag;
		logic [`MCALU_DATA_W-1:0] value;
	} expect_t;

	logic               clk;
	logic               rst_n_i;
	mcalu_pkg::issue_t  issue_i;
	mcalu_pkg::result_t result_o;

	expect_t     exp_q [$];
	logic [31:0] cyc;
	logic [31:0] rng;
	int          error_count;
	int          checked_count;

	mcalu_top uut (.clk(clk), .rst_n_i(rst_n_i), .issue_i(issue_i), .result_o(result_o));

	always #(PERIOD / 2) clk = ~clk;

	// Number of rising edges seen so far
	always @(posedge clk) cyc <= cyc + 1;

	// ====================
	// Helpers
	// ====================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// One draw in eight each lands on zero, all ones or the most negative value
	function automatic logic [31:0] pick_operand(input logic [31:0] r);
		case (r[2:0])
			3'd0: return 32'h0000_0000;
			3'd1: return 32'hffff_ffff;
			3'd2: return 32'h8000_0000;
			default: return xorshift(r);
		endcase
	endfunction

	function automatic logic [31:0] count_leading_zeros(input logic [31:0] x);
		int n;
		n = 0;
		while (n < 32 && !x[31-n]) n++;
		return 32'(n);
	endfunction

	function automatic logic [31:0] reverse_bits(input logic [31:0] x);
		logic [31:0] y;
		for (int i = 0; i < 32; i++) y[31-i] = x[i];
		return y;
	endfunction

	// Reference model, everything wraps modulo 2^32
	function automatic logic [31:0] model_result(input mcalu_pkg::issue_t is);
		logic [31:0] prod;
		prod = is.a * is.b;
		case (is.instr.opcode)
			mcalu_pkg::OP_MULI: return is.a * is.imm;
			mcalu_pkg::OP_MADD: return prod + is.c;
			mcalu_pkg::OP_MSUB: return prod - is.c;
			mcalu_pkg::OP_NMADD: return is.c - prod;
			mcalu_pkg::OP_NMSUB: return 32'h0 - prod - is.c;
			mcalu_pkg::OP_UNARY: begin
				case (is.instr.fn)
					mcalu_pkg::FN_CLZ: return count_leading_zeros(is.a);
					mcalu_pkg::FN_POPCNT: return 32'($countones(is.a));
					mcalu_pkg::FN_BREV: return reverse_bits(is.a);
					mcalu_pkg::FN_ABS: return is.a[31] ? 32'h0 - is.a : is.a;
					default: return 32'h0;
				endcase
			end
			default: return 32'h0;
		endcase
	endfunction

	task automatic make_issue(output mcalu_pkg::issue_t is);
		logic [31:0] r;
		rng = xorshift(rng);
		r = rng;
		// About three cycles in four carry an issue
		is.valid = (r[1:0] != 2'b00);
		if (r[5:2] < 4'd12) is.instr.opcode = LEGAL_OPS[r[10:6] % 6];
		else is.instr.opcode = mcalu_pkg::opcode_e'(r[14:11]);
		if (r[16:15] != 2'b00) is.instr.fn = LEGAL_FNS[r[18:17]];
		else is.instr.fn = mcalu_pkg::unary_fn_e'(r[22:19]);
		is.tag = r[26:23];
		rng = xorshift(rng);
		is.instr.rsvd = rng[31:8];
		rng = xorshift(rng);
		is.a = pick_operand(rng);
		rng = xorshift(rng);
		is.b = pick_operand(rng);
		rng = xorshift(rng);
		is.c = pick_operand(rng);
		rng = xorshift(rng);
		is.imm = pick_operand(rng);
	endtask

	task automatic stop_run();
		$display("Something failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %s: actual 0x%h, expected 0x%h", name, actual, expected);
			stop_run();
		end
	endtask

	task automatic report_problem(input string why);
		error_count++;
		$display("%s", why);
		stop_run();
	endtask

	// ====================
	// Stimulus
	// ====================

	initial begin
		mcalu_pkg::issue_t item;
		expect_t           entry;
		clk = 1'b0;
		rst_n_i = 1'b0;
		issue_i = '0;
		cyc = '0;
		rng = 32'he9b8_3c70;
		error_count = 0;
		checked_count = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;
		for (int i = 0; i < NUM_ISSUES; i++) begin
			@(posedge clk);
			make_issue(item);
			issue_i <= item;
			if (item.valid) begin
				// cyc still holds the count from before this edge
				entry.due = cyc + 1 + LATENCY;
				entry.tag = item.tag;
				entry.value = model_result(item);
				exp_q.push_back(entry);
			end
		end
		@(posedge clk);
		issue_i <= '0;
		// The watchdog bounds this wait
		while (exp_q.size() != 0) @(posedge clk);
		// Idle cycles catch any late or extra result
		repeat (DRAIN_CYCLES) @(posedge clk);
		$display("Checked %0d results", checked_count);
		if (error_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "Errors were seen");
		end
	end

	// ====================
	// Scoreboard
	// ====================

	// Outputs are sampled on the falling edge, half a period after they settle
	always @(negedge clk) begin
		expect_t head;
		if (rst_n_i) begin
			if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
				head = exp_q.pop_front();
				if (result_o.valid !== 1'b1) begin
					report_problem($sformatf("Missing result for tag 0x%h at cycle %0d",
						head.tag, cyc));
				end
				check_value("result_o.tag", 32'(result_o.tag), 32'(head.tag));
				check_value("result_o.value", result_o.value, head.value);
				checked_count++;
			end else if (result_o.valid !== 1'b0) begin
				report_problem($sformatf("Unexpected result with no issue at cycle %0d", cyc));
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		report_problem("Timeout, the run did not finish within the expected time");
	end

endmodule

`default_nettype wire

// ==== src/mcalu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mcalu_config.svh"

module mcalu_top (
	input  logic               clk,
	input  logic               rst_n_i,
	input  mcalu_pkg::issue_t  issue_i,
	output mcalu_pkg::result_t result_o
);

	mcalu_pkg::ctrl_t     dec_ctrl;
	mcalu_pkg::mul_op_t   dec_mul_op;
	mcalu_pkg::unary_op_t dec_unary_op;

	// Control word after it has kept pace with the multiply pipe
	mcalu_pkg::ctrl_t         sel_ctrl;
	logic [`MCALU_DATA_W-1:0] mul_value;
	logic [`MCALU_DATA_W-1:0] unary_value;
	logic [`MCALU_DATA_W-1:0] unary_value_aligned;

	mcalu_decode u_decode (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.issue_i    (issue_i),
		.ctrl_o     (dec_ctrl),
		.mul_op_o   (dec_mul_op),
		.unary_op_o (dec_unary_op)
	);

	mcalu_mul_pipe u_mul_pipe (.clk(clk), .mul_op_i(dec_mul_op), .value_o(mul_value));

	mcalu_unary_pipe u_unary_pipe (.clk(clk), .unary_op_i(dec_unary_op), .value_o(unary_value));

	// ====================
	// Alignment
	// ====================

	mcalu_delay #(.WIDTH($bits(mcalu_pkg::ctrl_t)), .DEPTH(`MCALU_MUL_STAGES)) u_ctrl_delay (
		.clk(clk), .rst_n_i(rst_n_i), .data_i(dec_ctrl), .data_o(sel_ctrl)
	);

	// The unary unit is shorter, so its result waits for the multiply depth
	mcalu_delay #(
		.WIDTH (`MCALU_DATA_W),
		.DEPTH (`MCALU_MUL_STAGES - `MCALU_UNARY_STAGES)
	) u_unary_delay (
		.clk(clk), .rst_n_i(1'b1), .data_i(unary_value), .data_o(unary_value_aligned)
	);

	mcalu_select u_select (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.ctrl_i        (sel_ctrl),
		.mul_value_i   (mul_value),
		.unary_value_i (unary_value_aligned),
		.result_o      (result_o)
	);

endmodule

`default_nettype wire

// ==== src/mcalu_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mcalu_config.svh"

module mcalu_select (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  mcalu_pkg::ctrl_t          ctrl_i,
	input  logic [`MCALU_DATA_W-1:0]  mul_value_i,
	input  logic [`MCALU_DATA_W-1:0]  unary_value_i,
	output mcalu_pkg::result_t        result_o
);

	logic [`MCALU_DATA_W-1:0] value_c;

	// ====================
	// Result mux
	// ====================

	// Both unit outputs are already aligned with ctrl_i here
	always_comb begin
		case (ctrl_i.unit)
			mcalu_pkg::UNIT_MUL: value_c = mul_value_i;
			mcalu_pkg::UNIT_UNARY: value_c = unary_value_i;
			// Unimplemented operations still retire, with a zero result
			default: value_c = '0;
		endcase
	end

	// Output register, valid for one cycle per completed instruction
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			result_o.valid <= 1'b0;
		end else begin
			result_o.valid <= ctrl_i.valid;
		end
		result_o.tag <= ctrl_i.tag;
		result_o.value <= value_c;
	end

endmodule

`default_nettype wire

// ==== src/mcalu_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcalu_delay #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 2
) (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic [WIDTH-1:0] data_i,
	output logic [WIDTH-1:0] data_o
);

	// One entry per cycle of delay, entry 0 is loaded first
	logic [WIDTH-1:0] stage_q [DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < DEPTH; i++) stage_q[i] <= '0;
		end else begin
			stage_q[0] <= data_i;
			for (int i = 1; i < DEPTH; i++) stage_q[i] <= stage_q[i-1];
		end
	end

	assign data_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== src/mcalu_unary_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mcalu_config.svh"

module mcalu_unary_pipe (
	input  logic                      clk,
	input  mcalu_pkg::unary_op_t      unary_op_i,
	output logic [`MCALU_DATA_W-1:0]  value_o
);

	localparam int W = `MCALU_DATA_W;
	// Counts run from 0 to W inclusive
	localparam int CNT_W = $clog2(W) + 1;

	logic [CNT_W-1:0] clz_c;
	logic [CNT_W-1:0] pop_c;
	logic [W-1:0]     brev_c;
	logic [W-1:0]     abs_c;

	mcalu_pkg::unary_fn_e s1_fn;
	logic [CNT_W-1:0]     s1_clz;
	logic [CNT_W-1:0]     s1_pop;
	logic [W-1:0]         s1_brev;
	logic [W-1:0]         s1_abs;

	// ====================
	// Stage 1 compute
	// ====================

	always_comb begin
		// The highest set bit is visited last and wins, zero leaves W
		clz_c = CNT_W'(W);
		pop_c = '0;
		for (int i = 0; i < W; i++) begin
			if (unary_op_i.operand[i]) clz_c = CNT_W'(W - 1 - i);
			pop_c = pop_c + CNT_W'(unary_op_i.operand[i]);
			brev_c[i] = unary_op_i.operand[W-1-i];
		end
		// Negating the most negative value wraps back to itself
		abs_c = unary_op_i.operand[W-1] ? (~unary_op_i.operand + 1'b1) : unary_op_i.operand;
	end

	always_ff @(posedge clk) begin
		s1_fn <= unary_op_i.fn;
		s1_clz <= clz_c;
		s1_pop <= pop_c;
		s1_brev <= brev_c;
		s1_abs <= abs_c;
	end

	// Stage 2 picks one result by function code
	always_ff @(posedge clk) begin
		case (s1_fn)
			mcalu_pkg::FN_CLZ: value_o <= {{(W-CNT_W){1'b0}}, s1_clz};
			mcalu_pkg::FN_POPCNT: value_o <= {{(W-CNT_W){1'b0}}, s1_pop};
			mcalu_pkg::FN_BREV: value_o <= s1_brev;
			mcalu_pkg::FN_ABS: value_o <= s1_abs;
			default: value_o <= '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/mcalu_mul_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mcalu_config.svh"

module mcalu_mul_pipe (
	input  logic                      clk,
	input  mcalu_pkg::mul_op_t        mul_op_i,
	output logic [`MCALU_DATA_W-1:0]  value_o
);

	localparam int W = `MCALU_DATA_W;
	localparam int HALF = W / 2;

	// Stage 1 holds the operands
	logic [W-1:0] s1_mcand;
	logic [W-1:0] s1_mplier;
	logic [W-1:0] s1_addend;
	logic         s1_neg;
	logic         s1_sub;

	// Stage 2 holds the two partial products
	logic [W-1:0]    s2_pp_lo;
	logic [HALF-1:0] s2_pp_hi;
	logic [W-1:0]    s2_addend;
	logic            s2_neg;
	logic            s2_sub;

	// Stage 3 holds the low half of the full product
	logic [W-1:0] s3_prod;
	logic [W-1:0] s3_addend;
	logic         s3_neg;
	logic         s3_sub;

	logic [W-1:0] prod_c;
	logic [W-1:0] addend_c;

	always_ff @(posedge clk) begin
		s1_mcand <= mul_op_i.multiplicand;
		s1_mplier <= mul_op_i.multiplier;
		s1_addend <= mul_op_i.addend;
		s1_neg <= mul_op_i.neg_prod;
		s1_sub <= mul_op_i.sub_addend;
		// Only the low 32 product bits are kept, so the high-by-high term drops out
		s2_pp_lo <= s1_mcand * {{HALF{1'b0}}, s1_mplier[HALF-1:0]};
		s2_pp_hi <= s1_mcand[HALF-1:0] * s1_mplier[W-1:HALF];
		s2_addend <= s1_addend;
		s2_neg <= s1_neg;
		s2_sub <= s1_sub;
		s3_prod <= s2_pp_lo + {s2_pp_hi, {HALF{1'b0}}};
		s3_addend <= s2_addend;
		s3_neg <= s2_neg;
		s3_sub <= s2_sub;
		value_o <= prod_c + addend_c;
	end

	// Sign handling is two's complement, modulo 2^32
	always_comb begin
		prod_c = s3_neg ? (~s3_prod + 1'b1) : s3_prod;
		addend_c = s3_sub ? (~s3_addend + 1'b1) : s3_addend;
	end

endmodule

`default_nettype wire

// ==== src/mcalu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcalu_decode (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  mcalu_pkg::issue_t    issue_i,
	output mcalu_pkg::ctrl_t     ctrl_o,
	output mcalu_pkg::mul_op_t   mul_op_o,
	output mcalu_pkg::unary_op_t unary_op_o
);

	mcalu_pkg::unit_e   unit_c;
	mcalu_pkg::mul_op_t mul_c;

	// ====================
	// Opcode decode
	// ====================

	always_comb begin
		// Default is a plain a*b+c, with no unit selected
		unit_c = mcalu_pkg::UNIT_NONE;
		mul_c.multiplicand = issue_i.a;
		mul_c.multiplier = issue_i.b;
		mul_c.addend = issue_i.c;
		mul_c.neg_prod = 1'b0;
		mul_c.sub_addend = 1'b0;
		case (issue_i.instr.opcode)
			mcalu_pkg::OP_UNARY: begin
				// Only the four known functions reach the unary unit
				case (issue_i.instr.fn)
					mcalu_pkg::FN_CLZ, mcalu_pkg::FN_POPCNT,
					mcalu_pkg::FN_BREV, mcalu_pkg::FN_ABS: unit_c = mcalu_pkg::UNIT_UNARY;
					default: unit_c = mcalu_pkg::UNIT_NONE;
				endcase
			end
			mcalu_pkg::OP_MULI: begin
				// Immediate replaces b and nothing is accumulated
				unit_c = mcalu_pkg::UNIT_MUL;
				mul_c.multiplier = issue_i.imm;
				mul_c.addend = '0;
			end
			mcalu_pkg::OP_MADD: unit_c = mcalu_pkg::UNIT_MUL;
			mcalu_pkg::OP_MSUB: begin
				unit_c = mcalu_pkg::UNIT_MUL;
				mul_c.sub_addend = 1'b1;
			end
			mcalu_pkg::OP_NMADD: begin
				unit_c = mcalu_pkg::UNIT_MUL;
				mul_c.neg_prod = 1'b1;
			end
			mcalu_pkg::OP_NMSUB: begin
				unit_c = mcalu_pkg::UNIT_MUL;
				mul_c.neg_prod = 1'b1;
				mul_c.sub_addend = 1'b1;
			end
			default: unit_c = mcalu_pkg::UNIT_NONE;
		endcase
	end

	// Micro-op register, the first pipeline stage
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ctrl_o.valid <= 1'b0;
		end else begin
			ctrl_o.valid <= issue_i.valid;
		end
		ctrl_o.tag <= issue_i.tag;
		ctrl_o.unit <= unit_c;
		mul_op_o <= mul_c;
		unary_op_o.fn <= issue_i.instr.fn;
		unary_op_o.operand <= issue_i.a;
	end

endmodule

`default_nettype wire

// ==== src/mcalu_pkg.sv ====
`default_nettype none

`include "mcalu_config.svh"

package mcalu_pkg;

	// ====================
	// Encodings
	// ====================

	// Major opcode in the top nibble of the instruction word
	typedef enum logic [3:0] {
		OP_UNARY = 4'h0,
		OP_MULI  = 4'h1,
		OP_MADD  = 4'h4,
		OP_MSUB  = 4'h5,
		OP_NMADD = 4'h6,
		OP_NMSUB = 4'h7
	} opcode_e;

	// Function select for OP_UNARY
	typedef enum logic [3:0] {
		FN_CLZ    = 4'h0,
		FN_POPCNT = 4'h1,
		FN_BREV   = 4'h2,
		FN_ABS    = 4'h3
	} unary_fn_e;

	// Which unit's result the select stage picks up
	typedef enum logic [1:0] {
		UNIT_NONE  = 2'd0,
		UNIT_MUL   = 2'd1,
		UNIT_UNARY = 2'd2
	} unit_e;

	// ====================
	// Bundles
	// ====================

	typedef struct packed {
		opcode_e   opcode;
		unary_fn_e fn;
		logic [23:0] rsvd;
	} instr_t;

	typedef struct packed {
		logic valid;
		instr_t instr;
		logic [`MCALU_DATA_W-1:0] a;
		logic [`MCALU_DATA_W-1:0] b;
		logic [`MCALU_DATA_W-1:0] c;
		logic [`MCALU_DATA_W-1:0] imm;
		logic [`MCALU_TAG_W-1:0] tag;
	} issue_t;

	typedef struct packed {
		logic [`MCALU_DATA_W-1:0] multiplicand;
		logic [`MCALU_DATA_W-1:0] multiplier;
		logic [`MCALU_DATA_W-1:0] addend;
		logic neg_prod;
		logic sub_addend;
	} mul_op_t;

	typedef struct packed {
		unary_fn_e fn;
		logic [`MCALU_DATA_W-1:0] operand;
	} unary_op_t;

	// Control word that runs alongside the data
	typedef struct packed {
		logic valid;
		logic [`MCALU_TAG_W-1:0] tag;
		unit_e unit;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		logic [`MCALU_TAG_W-1:0] tag;
		logic [`MCALU_DATA_W-1:0] value;
	} result_t;

endpackage

`default_nettype wire

// ==== src/mcalu_config.svh ====
`ifndef MCALU_CONFIG_SVH
`define MCALU_CONFIG_SVH

// ====================
// Datapath sizing
// ====================

// Operand and result width of the execution unit
`define MCALU_DATA_W 32
// Width of the result tag handed back to the core
`define MCALU_TAG_W 4

// Register stages in the multiply-accumulate pipeline
`define MCALU_MUL_STAGES 4
// Register stages in the unary pipeline, before alignment
`define MCALU_UNARY_STAGES 2

`endif
